/* sim/video_bridge_patterns.txt */
# name gap lines base
# gap is the blanking after each camera line in cycles, base (hex) is pixel 0 of line 0
basic 10 8 10
min_gap 8 8 00
long_gap 24 9 40
wrap_pixels 12 10 fa
extra_lines 8 12 f0
many_lines 16 14 80
mixed 14 11 3c

/* video_bridge.f */
design/video_bridge_pkg.sv
design/cam_capture.sv
design/line_buffer.sv
design/sync_gen.sv
design/video_out.sv
design/video_bridge.sv
sim/video_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module video_bridge_tb -f video_bridge.f \
    --Mdir obj_dir -o video_bridge_sim \
  && ./obj_dir/video_bridge_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim/video_bridge_tb.sv */
`timescale 1ns/100ps

module video_bridge_tb;
    import video_bridge_pkg::*;

    localparam int H_ACT = 16, H_FP = 4, H_SYNC = 3, V_FP = 1, V_SYNC = 1, V_ACT = 6;
    localparam int V_TOTAL = V_FP + V_SYNC + V_ACT;

    logic clk = 1'b0, rstn = 1'b0, cam_href = 1'b0, cam_vsync = 1'b0;
    pixel_t cam_data = '0;
    logic hsync, vsync, de;
    pixel_t pix;

    logic [8*24-1:0] test_name [16], cur_name;
    int test_gap [16], test_lines [16];
    pixel_t test_base [16];
    int n_tests = 0, cycle_limit = 100, cyc = 0, err_cnt = 0, n_passed = 0;
    int done_cnt, bursts, pix_idx, hs_run;
    int exp_rise [$];  // edge after which a passive hsync must rise
    pixel_t line_base, last_done, burst_first;
    pixel_t done_hist [4];
    logic href_q = 1'b0, hsync_q = 1'b0, de_q = 1'b0;

    video_bridge #(.H_ACT(H_ACT), .H_FP(H_FP), .H_SYNC(H_SYNC), .V_FP(V_FP),
                   .V_SYNC(V_SYNC), .V_ACT(V_ACT)) dut (.*);

    always #50 clk = ~clk;

    task automatic value_error(string what, int exp_v, int act_v);
        $display("ERROR %0s %0s expected %0d actual %0d", cur_name, what, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic problem(string msg);
        $display("test %0s: %0s", cur_name, msg);
        err_cnt++;
    endtask

    // ====================================================================
    // display monitor, samples outputs as they were before the edge
    // ====================================================================

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (href_q && !cam_href) begin
            last_done = line_base;  // wr_bank flips on this edge
            done_cnt  = done_cnt + 1;
        end
        href_q = cam_href;
        done_hist[3] = done_hist[2];
        done_hist[2] = done_hist[1];
        done_hist[1] = done_hist[0];
        done_hist[0] = last_done;
        if (hsync && !hsync_q) begin
            hs_run = 0;
            if (exp_rise.size() > 0) begin
                if (exp_rise[0] != cyc - 1) value_error("hsync rise edge", exp_rise[0], cyc - 1);
                void'(exp_rise.pop_front());
            end
        end
        if (hsync) hs_run = hs_run + 1;
        if (!hsync && hsync_q && hs_run != H_SYNC) value_error("hsync width", H_SYNC, hs_run);
        hsync_q = hsync;
        if (de && !de_q) begin
            pix_idx     = 0;
            burst_first = done_hist[3];  // line finished by the line_start edge, 3 edges back
            if (done_cnt < V_TOTAL) problem("display line started before the frame was counted");
            if (vsync != (bursts < V_SYNC)) value_error("vsync", bursts < V_SYNC, vsync);
        end
        if (de) begin
            if (pix !== pixel_t'(burst_first + pix_idx)) begin
                value_error("pix", pixel_t'(burst_first + pix_idx), pix);
            end
            pix_idx = pix_idx + 1;
        end
        if (!de && de_q) begin
            if (pix_idx != H_ACT) value_error("de width", H_ACT, pix_idx);
            bursts = bursts + 1;
        end
        de_q = de;
    end

    always @(posedge clk) begin
        if (cyc > cycle_limit) begin
            $display("timeout after %0d cycles, the display frame never completed", cyc);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ====================================================================
    // stimulus
    // ====================================================================

    task automatic read_patterns(int fd);
        logic [8*24-1:0] tok;
        logic [8*128-1:0] rest;
        int code, base;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1 && tok == "#") begin
                code = $fgets(rest, fd);  // column description
            end else if (code == 1) begin
                code = $fscanf(fd, "%d %d %h", test_gap[n_tests], test_lines[n_tests], base);
                test_name[n_tests] = tok;
                test_base[n_tests] = pixel_t'(base);
                cycle_limit += 4 * (test_lines[n_tests] * (H_ACT + test_gap[n_tests] + 3) + 20);
                n_tests++;
            end
        end
    endtask

    task automatic send_line(pixel_t start, int gap, logic passive);
        line_base = start;
        for (int i = 0; i < H_ACT; i++) begin
            @(posedge clk);
            #1 cam_href = 1'b1;
            cam_data = start + pixel_t'(i);
        end
        @(posedge clk);
        #1 cam_href = 1'b0;
        cam_data = '0;
        if (passive) exp_rise.push_back(cyc + H_FP + 2);
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic finish_test(int errs_before);
        if (err_cnt == errs_before) n_passed++;
        $display("test %0s: %0s", cur_name, (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic check_reset_state();
        cur_name = "after_reset";
        repeat (8) @(posedge clk);
        #1 rstn = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            if (hsync || vsync || de) problem("hsync, vsync or de high before any href");
        end
        finish_test(0);
    endtask

    task automatic run_one(int t);
        int errs_before;
        int idle;
        int idle_limit;
        cur_name = test_name[t];
        errs_before = err_cnt;
        idle_limit = test_gap[t] + 2 + H_ACT + H_FP + H_SYNC;
        bursts = 0;
        done_cnt = 0;
        @(posedge clk);
        #1 cam_vsync = 1'b1;  // new camera frame
        @(posedge clk);
        #1 cam_vsync = 1'b0;
        for (int k = 0; k < test_lines[t]; k++) begin
            send_line(test_base[t] + pixel_t'(k), test_gap[t] + int'($urandom % 3), k < V_TOTAL);
        end
        // a whole line without sync or data means the controller follows the camera again
        idle = 0;
        while (idle < idle_limit) begin
            @(posedge clk);
            if (hsync || de) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        #1;
        if (bursts != V_TOTAL) value_error("de bursts", V_TOTAL, bursts);
        if (exp_rise.size() != 0) problem("a passive hsync pulse never appeared");
        if (vsync) problem("vsync still high after the active phase");
        exp_rise.delete();
        finish_test(errs_before);
    endtask

    initial begin
        int fd;
        void'($urandom(32'h594abc5a));
        fd = $fopen("sim/video_bridge_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/video_bridge_patterns.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            read_patterns(fd);
            $fclose(fd);
            check_reset_state();
            for (int t = 0; t < n_tests; t++) run_one(t);
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     n_tests + 1, n_passed, n_tests + 1 - n_passed, err_cnt);
            if (err_cnt == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule : video_bridge_tb

/* design/video_bridge.sv */
`timescale 1ns/100ps

module video_bridge #(
    parameter int H_ACT  = 16,
    parameter int H_FP   = 4,
    parameter int H_SYNC = 3,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_ACT  = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cam_href,
    input  logic                     cam_vsync,
    input  video_bridge_pkg::pixel_t cam_data,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output video_bridge_pkg::pixel_t pix
);
    import video_bridge_pkg::*;

    localparam int ADDR_W = $clog2(H_ACT + 1);

    logic              href_rise;
    logic              href_fall;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_data;
    logic              wr_bank;
    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_data;
    sync_state_t       state;
    logic              line_start;

    // ====================================================================
    // camera side, line store, timing and display side
    // ====================================================================

    cam_capture #(
        .H_ACT(H_ACT)
    ) u_cam_capture (
        .clk      (clk),
        .rstn     (rstn),
        .cam_href (cam_href),
        .cam_data (cam_data),
        .href_rise(href_rise),
        .href_fall(href_fall),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_bank  (wr_bank)
    );

    line_buffer #(
        .H_ACT(H_ACT)
    ) u_line_buffer (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_bank(wr_bank),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    sync_gen #(
        .H_ACT (H_ACT),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_ACT (V_ACT)
    ) u_sync_gen (
        .clk       (clk),
        .rstn      (rstn),
        .href_rise (href_rise),
        .href_fall (href_fall),
        .cam_vsync (cam_vsync),
        .hsync     (hsync),
        .state     (state),
        .line_start(line_start)
    );

    video_out #(
        .H_ACT (H_ACT),
        .V_SYNC(V_SYNC)
    ) u_video_out (
        .clk       (clk),
        .rstn      (rstn),
        .state     (state),
        .line_start(line_start),
        .rd_data   (rd_data),
        .rd_addr   (rd_addr),
        .de        (de),
        .pix       (pix),
        .vsync     (vsync)
    );

endmodule : video_bridge

/* design/video_out.sv */
`timescale 1ns/100ps

module video_out #(
    parameter  int H_ACT  = 16,
    parameter  int V_SYNC = 1,
    localparam int ADDR_W = $clog2(H_ACT + 1)
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  video_bridge_pkg::sync_state_t state,
    input  logic                          line_start,
    input  video_bridge_pkg::pixel_t      rd_data,
    output logic [ADDR_W-1:0]             rd_addr,
    output logic                          de,
    output video_bridge_pkg::pixel_t      pix,
    output logic                          vsync
);
    import video_bridge_pkg::*;

    localparam int LC_W = $clog2(V_SYNC + 1);

    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(H_ACT - 1);
    localparam logic [LC_W-1:0]   LC_MAX    = LC_W'(V_SYNC);

    logic            reading;
    logic            rd_valid;  // rd_data holds a line pixel
    logic [LC_W-1:0] line_cnt;

    assign reading = (state == ACTIVE_H_ACTIVE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_addr  <= '0;
            rd_valid <= 1'b0;
            de       <= 1'b0;
            line_cnt <= '0;
            vsync    <= 1'b0;
        end else begin
            if (reading && rd_addr != ADDR_LAST) begin
                rd_addr <= rd_addr + 1'b1;
            end else begin
                rd_addr <= '0;
            end
            rd_valid <= reading;
            de       <= rd_valid;

            // vsync covers the first V_SYNC display lines of each active phase
            if (!is_active_phase(state)) begin
                line_cnt <= '0;
                vsync    <= 1'b0;
            end else if (line_start) begin
                vsync <= (line_cnt != LC_MAX);
                if (line_cnt != LC_MAX) begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        pix <= rd_data;
    end

    de_burst_a: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(de) |-> ##H_ACT !de
    );

endmodule : video_out

/* design/sync_gen.sv */
`timescale 1ns/100ps

module sync_gen #(
    parameter int H_ACT  = 16,
    parameter int H_FP   = 4,
    parameter int H_SYNC = 3,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_ACT  = 6
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          href_rise,
    input  logic                          href_fall,
    input  logic                          cam_vsync,
    output logic                          hsync,
    output video_bridge_pkg::sync_state_t state,
    output logic                          line_start
);
    import video_bridge_pkg::*;

    localparam int V_TOTAL = V_FP + V_SYNC + V_ACT;
    localparam int H_TOTAL = H_FP + H_SYNC + H_ACT;
    localparam int H_W     = $clog2(4 * H_TOTAL);  // room for a gap of a few line lengths
    localparam int V_W     = $clog2(V_TOTAL + 1);

    localparam logic [H_W-1:0] ACT_LAST  = H_W'(H_ACT - 1);
    localparam logic [H_W-1:0] FP_LAST   = H_W'(H_FP - 1);
    localparam logic [H_W-1:0] SYNC_LAST = H_W'(H_SYNC - 1);
    localparam logic [V_W-1:0] V_LAST    = V_W'(V_TOTAL);

    logic [H_W-1:0] h_cnt;
    logic [H_W-1:0] h_total;  // measured camera blanking gap
    logic [V_W-1:0] v_cnt;
    logic           vsynced;

    // ====================================================================
    // two-phase line timing FSM
    // ====================================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= PASSIVE_H_ACTIVE;
            h_cnt      <= '0;
            h_total    <= '0;
            v_cnt      <= '0;
            hsync      <= 1'b0;
            line_start <= 1'b0;
            vsynced    <= 1'b0;
        end else begin
            line_start <= 1'b0;

            case (state)
                PASSIVE_H_ACTIVE: begin
                    if (href_fall) begin
                        // a camera vsync makes this the first line of a new frame
                        v_cnt   <= vsynced ? V_W'(1) : v_cnt + 1'b1;
                        vsynced <= 1'b0;
                        h_cnt   <= '0;
                        state   <= PASSIVE_H_FP;
                    end
                end
                PASSIVE_H_FP: begin
                    if (h_cnt != FP_LAST) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b1;
                        state <= PASSIVE_H_SYNC;
                    end
                end
                PASSIVE_H_SYNC: begin
                    if (h_cnt != SYNC_LAST) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b0;
                        if (v_cnt >= V_LAST) begin
                            v_cnt <= '0;  // display lines are counted from here on
                            state <= ACTIVE_H_WAIT_REF;
                        end else begin
                            h_total <= '0;
                            state   <= PASSIVE_H_WAIT_REF;
                        end
                    end
                end
                PASSIVE_H_WAIT_REF: begin
                    if (href_rise) begin
                        state <= PASSIVE_H_ACTIVE;
                    end else if (h_total != '1) begin
                        h_total <= h_total + 1'b1;  // saturates on an idle camera
                    end
                end

                ACTIVE_H_WAIT_REF: begin
                    if (h_cnt + 1'b1 < h_total) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt      <= '0;
                        line_start <= 1'b1;
                        state      <= ACTIVE_H_ACTIVE;
                    end
                end
                ACTIVE_H_ACTIVE: begin
                    if (h_cnt != ACT_LAST) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        v_cnt <= v_cnt + 1'b1;
                        state <= ACTIVE_H_FP;
                    end
                end
                ACTIVE_H_FP: begin
                    if (h_cnt != FP_LAST) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b1;
                        state <= ACTIVE_H_SYNC;
                    end
                end
                ACTIVE_H_SYNC: begin
                    if (h_cnt != SYNC_LAST) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b0;
                        if (v_cnt >= V_LAST) begin
                            v_cnt <= '0;  // frame done, follow the camera again
                            state <= PASSIVE_H_ACTIVE;
                        end else begin
                            state <= ACTIVE_H_WAIT_REF;
                        end
                    end
                end
            endcase

            if (cam_vsync) begin
                vsynced <= 1'b1;
            end
        end
    end

    hsync_width_a: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(hsync) |-> ##H_SYNC !hsync
    );

endmodule : sync_gen

/* design/line_buffer.sv */
`timescale 1ns/100ps

module line_buffer #(
    parameter  int H_ACT  = 16,
    localparam int ADDR_W = $clog2(H_ACT + 1)
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [ADDR_W-1:0]        wr_addr,
    input  video_bridge_pkg::pixel_t wr_data,
    input  logic                     wr_bank,
    input  logic [ADDR_W-1:0]        rd_addr,
    output video_bridge_pkg::pixel_t rd_data
);
    import video_bridge_pkg::*;

    localparam int IDX_W = $clog2(H_ACT);

    pixel_t mem [2][H_ACT];

    logic rd_bank;
    logic rd_bank_q;
    logic wr_ok;

    assign wr_ok = wr_en && (wr_addr < ADDR_W'(H_ACT));

    // the read bank is only re-picked at address 0 so one display line stays on one bank
    assign rd_bank = (rd_addr == '0) ? ~wr_bank : rd_bank_q;

    // ====================================================================
    // ping-pong storage
    // ====================================================================

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_bank][wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_bank_q <= rd_bank;
        rd_data   <= mem[rd_bank][rd_addr[IDX_W-1:0]];  // one cycle read latency
    end

endmodule : line_buffer

/* design/cam_capture.sv */
`timescale 1ns/100ps

module cam_capture #(
    parameter  int H_ACT  = 16,
    localparam int ADDR_W = $clog2(H_ACT + 1)
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cam_href,
    input  video_bridge_pkg::pixel_t cam_data,
    output logic                     href_rise,
    output logic                     href_fall,
    output logic                     wr_en,
    output logic [ADDR_W-1:0]        wr_addr,
    output video_bridge_pkg::pixel_t wr_data,
    output logic                     wr_bank
);

    logic href_d;
    logic fall_seen;

    assign fall_seen = ~cam_href & href_d;

    // a pixel is stored on the very edge that samples href high
    assign wr_en   = cam_href;
    assign wr_data = cam_data;

    // ====================================================================
    // href edges, write address and bank
    // ====================================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            href_d    <= 1'b0;
            href_rise <= 1'b0;
            href_fall <= 1'b0;
            wr_addr   <= '0;
            wr_bank   <= 1'b0;
        end else begin
            href_d    <= cam_href;
            href_rise <= cam_href & ~href_d;
            href_fall <= fall_seen;

            if (cam_href) begin
                wr_addr <= wr_addr + 1'b1;
            end else begin
                wr_addr <= '0;  // every line restarts at address 0
            end

            if (fall_seen) begin
                wr_bank <= ~wr_bank;  // the finished line is handed to the display side
            end
        end
    end

    // a camera line longer than the buffer would spill over the bank
    wr_addr_range_a: assert property (
        @(posedge clk) disable iff (!rstn)
        cam_href |-> (wr_addr < ADDR_W'(H_ACT))
    );

endmodule : cam_capture

/* design/video_bridge_pkg.sv */
package video_bridge_pkg;

    // ====================================================================
    // pixel payload
    // ====================================================================

    typedef logic [7:0] pixel_t;  // same width on the camera and display side

    // ====================================================================
    // line timing controller states
    // ====================================================================

    typedef enum logic [2:0] {
        PASSIVE_H_ACTIVE   = 3'b000,  // camera line in progress
        PASSIVE_H_FP       = 3'b001,
        PASSIVE_H_SYNC     = 3'b010,
        PASSIVE_H_WAIT_REF = 3'b011,  // blanking gap is being measured here
        ACTIVE_H_ACTIVE    = 3'b100,  // display line is read out of the buffer
        ACTIVE_H_FP        = 3'b101,
        ACTIVE_H_SYNC      = 3'b110,
        ACTIVE_H_WAIT_REF  = 3'b111   // replays the measured gap
    } sync_state_t;

    // true while the controller free-runs the display raster
    function automatic logic is_active_phase(sync_state_t s);
        return s inside {ACTIVE_H_ACTIVE, ACTIVE_H_FP, ACTIVE_H_SYNC, ACTIVE_H_WAIT_REF};
    endfunction

endpackage : video_bridge_pkg
